// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_rv32_core
FILELIST  := compile.f

SIM  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) verification/tb_iss_model.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+verification
rtl/rv32_pkg.sv
rtl/rv32_dec_if.sv
rtl/rv32_decoder.sv
rtl/rv32_regfile.sv
rtl/rv32_execute.sv
rtl/rv32_lsu.sv
rtl/rv32_pc_unit.sv
rtl/rv32_core.sv
verification/tb_rv32_core.sv

// ==== rtl/rv32_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_core #(
    parameter int              ADDR_WIDTH = 16,
    parameter rv32_pkg::word_t START_ADDR = 32'h10000
) (
    input  wire                   clk,
    input  wire                   reset_n,
    output logic                  ram_wr_en_o,
    output logic [3:0]            ram_wr_strobe_o,
    output logic [ADDR_WIDTH-1:0] ram_addr_o,
    output rv32_pkg::word_t       ram_data_in_o,
    input  wire rv32_pkg::word_t  ram_data_out_i,
    output rv32_pkg::fault_e      core_fault_o
);
    import rv32_pkg::*;

    rv32_dec_if dec_if ();

    word_t    instruction;
    word_t    pc;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     branch_taken;
    word_t    target;
    word_t    exe_result;
    logic     mem_stall;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    rv32_decoder u_decoder (
        .instruction_i (instruction),
        .dec           (dec_if)
    );

    rv32_regfile u_regfile (
        .clk        (clk),
        .reset_n    (reset_n),
        .rs1_i      (dec_if.rs1),
        .rs2_i      (dec_if.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_en_i    (wb_en),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data)
    );

    rv32_execute u_execute (
        .dec            (dec_if),
        .pc_i           (pc),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .branch_taken_o (branch_taken),
        .target_o       (target),
        .exe_result_o   (exe_result)
    );

    rv32_lsu #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_lsu (
        .clk             (clk),
        .reset_n         (reset_n),
        .dec             (dec_if),
        .pc_i            (pc),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .exe_result_i    (exe_result),
        .ram_data_out_i  (ram_data_out_i),
        .mem_stall_o     (mem_stall),
        .instruction_o   (instruction),
        .ram_addr_o      (ram_addr_o),
        .ram_wr_en_o     (ram_wr_en_o),
        .ram_wr_strobe_o (ram_wr_strobe_o),
        .ram_data_in_o   (ram_data_in_o),
        .wb_en_o         (wb_en),
        .wb_rd_o         (wb_rd),
        .wb_data_o       (wb_data)
    );

    rv32_pc_unit #(
        .START_ADDR (START_ADDR)
    ) u_pc_unit (
        .clk            (clk),
        .reset_n        (reset_n),
        .dec            (dec_if),
        .mem_stall_i    (mem_stall),
        .branch_taken_i (branch_taken),
        .target_i       (target),
        .pc_o           (pc),
        .core_fault_o   (core_fault_o)
    );

endmodule

`default_nettype wire

// ==== rtl/rv32_dec_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface rv32_dec_if;
    import rv32_pkg::*;

    opcode_e    opcode;
    logic [2:0] func3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm;       // already sign extended
    logic       alt;       // sub / sra
    wb_sel_e    wb_sel;
    logic       illegal;

    modport dec (output opcode, func3, rd, rs1, rs2, imm, alt, wb_sel, illegal);
    modport exe (input opcode, func3, imm, alt);
    modport mem (input opcode, func3, rd, imm, wb_sel, illegal);
    modport pc  (input opcode, illegal);

endinterface

`default_nettype wire

// ==== rtl/rv32_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_decoder (
    input  wire rv32_pkg::word_t instruction_i,
    rv32_dec_if.dec              dec
);
    import rv32_pkg::*;

    opcode_e    opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm;
    logic       alt;
    logic       illegal;
    wb_sel_e    wb_sel;

    assign opcode = opcode_e'(instruction_i[6:0]);
    assign func3  = instruction_i[14:12];
    assign func7  = instruction_i[31:25];

    assign imm_i = {{21{instruction_i[31]}}, instruction_i[30:20]};
    assign imm_s = {{21{instruction_i[31]}}, instruction_i[30:25], instruction_i[11:7]};
    assign imm_b = {{20{instruction_i[31]}}, instruction_i[7], instruction_i[30:25],
                    instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'd0};
    assign imm_j = {{12{instruction_i[31]}}, instruction_i[19:12], instruction_i[20],
                    instruction_i[30:21], 1'b0};

    always_comb begin
        imm     = imm_i;
        alt     = 1'b0;
        illegal = 1'b0;
        wb_sel  = wb_none;
        case (opcode)
            op_lui, op_auipc: begin
                imm    = imm_u;
                wb_sel = wb_alu;
            end
            op_jal: begin
                imm    = imm_j;
                wb_sel = wb_link;
            end
            op_jalr: wb_sel = wb_link;
            op_branch: begin
                imm     = imm_b;
                illegal = (func3 == 3'b010) || (func3 == 3'b011);
            end
            op_load: begin
                wb_sel  = wb_load;
                illegal = !(func3 inside {mem_b, mem_h, mem_w, mem_bu, mem_hu});
            end
            op_store: begin
                imm     = imm_s;
                illegal = !(func3 inside {mem_b, mem_h, mem_w});
            end
            op_op_imm: begin
                wb_sel = wb_alu;
                if (func3 == alu_sll) begin
                    illegal = (func7 != 7'd0);
                end else if (func3 == alu_sr) begin
                    alt     = (func7 == 7'b0100000);   // srai
                    illegal = (func7 != 7'd0) && !alt;
                end
            end
            op_op: begin
                wb_sel  = wb_alu;
                alt     = (func7 == 7'b0100000) && (func3 == alu_add || func3 == alu_sr);
                illegal = (func7 != 7'd0) && !alt;
            end
            op_misc_mem: ;                         // fence is a no-op
            op_system:   illegal = 1'b1;
            default:     illegal = 1'b1;
        endcase
    end

    assign dec.opcode  = opcode;
    assign dec.func3   = func3;
    assign dec.rd      = instruction_i[11:7];
    assign dec.rs1     = instruction_i[19:15];
    assign dec.rs2     = instruction_i[24:20];
    assign dec.imm     = imm;
    assign dec.alt     = alt;
    assign dec.wb_sel  = wb_sel;
    assign dec.illegal = illegal;

endmodule

`default_nettype wire

// ==== rtl/rv32_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_execute (
    rv32_dec_if.exe              dec,
    input  wire rv32_pkg::word_t pc_i,
    input  wire rv32_pkg::word_t rs1_data_i,
    input  wire rv32_pkg::word_t rs2_data_i,
    output logic                 branch_taken_o,
    output rv32_pkg::word_t      target_o,
    output rv32_pkg::word_t      exe_result_o
);
    import rv32_pkg::*;

    word_t      op_b;
    word_t      alu_result;
    logic [4:0] shamt;
    logic       cond;

    assign op_b  = (dec.opcode == op_op) ? rs2_data_i : dec.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        alu_result = '0;
        case (alu_op_e'(dec.func3))
            alu_add:  alu_result = (dec.alt && dec.opcode == op_op) ?
                                   rs1_data_i - op_b : rs1_data_i + op_b;
            alu_sll:  alu_result = rs1_data_i << shamt;
            alu_slt:  alu_result = {31'd0, $signed(rs1_data_i) < $signed(op_b)};
            alu_sltu: alu_result = {31'd0, rs1_data_i < op_b};
            alu_xor:  alu_result = rs1_data_i ^ op_b;
            alu_sr: begin
                if (dec.alt) begin
                    alu_result = $signed(rs1_data_i) >>> shamt;
                end else begin
                    alu_result = rs1_data_i >> shamt;
                end
            end
            alu_or:   alu_result = rs1_data_i | op_b;
            alu_and:  alu_result = rs1_data_i & op_b;
        endcase
    end

    // branch conditions by func3
    always_comb begin
        case (dec.func3)
            3'b000:  cond = (rs1_data_i == rs2_data_i);
            3'b001:  cond = (rs1_data_i != rs2_data_i);
            3'b100:  cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
            3'b101:  cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            3'b110:  cond = (rs1_data_i < rs2_data_i);
            3'b111:  cond = (rs1_data_i >= rs2_data_i);
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken_o = (dec.opcode == op_branch) && cond;
    assign target_o = (dec.opcode == op_jalr) ? rs1_data_i + dec.imm : pc_i + dec.imm;

    always_comb begin
        case (dec.opcode)
            op_lui:          exe_result_o = dec.imm;
            op_auipc:        exe_result_o = pc_i + dec.imm;
            op_jal, op_jalr: exe_result_o = pc_i + 32'd4;   // link
            default:         exe_result_o = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv32_lsu.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_lsu #(
    parameter int ADDR_WIDTH = 16
) (
    input  wire                   clk,
    input  wire                   reset_n,
    rv32_dec_if.mem               dec,
    input  wire rv32_pkg::word_t  pc_i,
    input  wire rv32_pkg::word_t  rs1_data_i,
    input  wire rv32_pkg::word_t  rs2_data_i,
    input  wire rv32_pkg::word_t  exe_result_i,
    input  wire rv32_pkg::word_t  ram_data_out_i,
    output logic                  mem_stall_o,
    output rv32_pkg::word_t       instruction_o,
    output logic [ADDR_WIDTH-1:0] ram_addr_o,
    output logic                  ram_wr_en_o,
    output logic [3:0]            ram_wr_strobe_o,
    output rv32_pkg::word_t       ram_data_in_o,
    output logic                  wb_en_o,
    output rv32_pkg::reg_idx_t    wb_rd_o,
    output rv32_pkg::word_t       wb_data_o
);
    import rv32_pkg::*;

    logic                  mem_stall;
    word_t                 held_inst;
    logic [ADDR_WIDTH+1:0] data_addr;   // byte address
    word_t                 addr_calc;
    logic                  is_store;
    logic                  is_mem;
    logic [7:0]            byte_lane;
    logic [15:0]           half_lane;
    word_t                 load_data;

    assign addr_calc = rs1_data_i + dec.imm;
    assign is_store  = (dec.opcode == op_store);
    assign is_mem    = (dec.opcode == op_load || is_store) && !dec.illegal;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mem_stall <= 1'b0;
        end else begin
            mem_stall <= !mem_stall && is_mem;   // single stall cycle
        end
    end

    // keep the fetched word for the replay cycle
    always_ff @(posedge clk) begin
        if (!mem_stall) begin
            held_inst <= ram_data_out_i;
            data_addr <= addr_calc[ADDR_WIDTH+1:0];
        end
    end

    assign mem_stall_o   = mem_stall;
    assign instruction_o = mem_stall ? held_inst : ram_data_out_i;
    assign ram_addr_o    = mem_stall ? data_addr[ADDR_WIDTH+1:2] : pc_i[ADDR_WIDTH+1:2];
    assign ram_wr_en_o   = mem_stall && is_store;

    always_comb begin
        ram_wr_strobe_o = 4'b1111;
        ram_data_in_o   = rs2_data_i;
        if (mem_stall && is_store) begin
            case (mem_size_e'(dec.func3))
                mem_b: begin
                    ram_wr_strobe_o = 4'b0001 << data_addr[1:0];
                    ram_data_in_o   = {4{rs2_data_i[7:0]}};
                end
                mem_h: begin
                    ram_wr_strobe_o = data_addr[1] ? 4'b1100 : 4'b0011;
                    ram_data_in_o   = {2{rs2_data_i[15:0]}};
                end
                default: ;   // full word
            endcase
        end
    end

    assign byte_lane = ram_data_out_i[{data_addr[1:0], 3'b000} +: 8];
    assign half_lane = ram_data_out_i[{data_addr[1], 4'b0000} +: 16];

    always_comb begin
        case (mem_size_e'(dec.func3))
            mem_b:   load_data = {{24{byte_lane[7]}}, byte_lane};
            mem_bu:  load_data = {24'd0, byte_lane};
            mem_h:   load_data = {{16{half_lane[15]}}, half_lane};
            mem_hu:  load_data = {16'd0, half_lane};
            default: load_data = ram_data_out_i;
        endcase
    end

    // loads write in the stall cycle, everything else before it
    assign wb_en_o = !dec.illegal && (mem_stall ? (dec.wb_sel == wb_load) :
                     (dec.wb_sel == wb_alu || dec.wb_sel == wb_link));
    assign wb_rd_o   = dec.rd;
    assign wb_data_o = (dec.wb_sel == wb_load) ? load_data : exe_result_i;

endmodule

`default_nettype wire

// ==== rtl/rv32_pc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_pc_unit #(
    parameter rv32_pkg::word_t START_ADDR = 32'h10000
) (
    input  wire                  clk,
    input  wire                  reset_n,
    rv32_dec_if.pc               dec,
    input  wire                  mem_stall_i,
    input  wire                  branch_taken_i,
    input  wire rv32_pkg::word_t target_i,
    output rv32_pkg::word_t      pc_o,
    output rv32_pkg::fault_e     core_fault_o
);
    import rv32_pkg::*;

    logic first_mem_cycle;
    logic hold;
    logic jump;

    assign first_mem_cycle = !mem_stall_i && (dec.opcode == op_load || dec.opcode == op_store);

    // a fault freezes the pc for good
    assign hold = dec.illegal || (core_fault_o != fault_ok) || first_mem_cycle;
    assign jump = branch_taken_i || dec.opcode == op_jal || dec.opcode == op_jalr;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc_o         <= START_ADDR;
            core_fault_o <= fault_ok;
        end else begin
            if (dec.illegal) begin
                core_fault_o <= fault_decode_err;
            end
            if (!hold) begin
                pc_o <= jump ? target_i : pc_o + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv32_pkg.sv ====
`default_nettype none

package rv32_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [6:0] {
        op_lui      = 7'b0110111,
        op_auipc    = 7'b0010111,
        op_jal      = 7'b1101111,
        op_jalr     = 7'b1100111,
        op_branch   = 7'b1100011,
        op_load     = 7'b0000011,
        op_store    = 7'b0100011,
        op_op_imm   = 7'b0010011,
        op_op       = 7'b0110011,
        op_misc_mem = 7'b0001111,
        op_system   = 7'b1110011   // not supported, decodes as illegal
    } opcode_e;

    // func3 of OP and OP_IMM
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_sr   = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_e;

    // func3 of LOAD and STORE
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_size_e;

    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_link,
        wb_load
    } wb_sel_e;

    typedef enum logic [3:0] {
        fault_ok         = 4'd0,
        fault_decode_err = 4'd1
    } fault_e;

endpackage

`default_nettype wire

// ==== rtl/rv32_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_regfile (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire rv32_pkg::reg_idx_t rs1_i,
    input  wire rv32_pkg::reg_idx_t rs2_i,
    output rv32_pkg::word_t         rs1_data_o,
    output rv32_pkg::word_t         rs2_data_o,
    input  wire                     wb_en_i,
    input  wire rv32_pkg::reg_idx_t wb_rd_i,
    input  wire rv32_pkg::word_t    wb_data_i
);
    import rv32_pkg::*;

    word_t regs [31:1];   // x0 is not stored

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_iss_model.svh ====
int    seed = 32'h343c;
word_t prog [$];
word_t iss_mem [0:65535];
word_t exp_fetch [$];
word_t exp_st_addr [$];
logic [3:0] exp_st_strb [$];
word_t exp_st_data [$];
fault_e exp_fault;

function automatic int rnd(input int n);
    return $unsigned($random(seed)) % n;
endfunction

// background pattern, a function of the whole word address
function automatic word_t fill_word(input int a);
    return {a[15:0] * 16'd40503, a[15:0] ^ 16'ha5c3};
endfunction

function automatic word_t enc_i(input int imm, input int rs1, input int f3, input int rd,
                                input int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic word_t enc_s(input int imm, input int rs2, input int rs1, input int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
endfunction

function automatic word_t enc_b(input int imm, input int rs1, input int rs2, input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
endfunction

function automatic word_t enc_u(input int imm, input int rd, input int op);
    return {imm[19:0], rd[4:0], op[6:0]};
endfunction

function automatic word_t enc_j(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
endfunction

function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic int mem_off(input int f3);
    case (f3 % 4)
        0:       return rnd(256);
        1:       return rnd(128) * 2;
        default: return rnd(64) * 4;
    endcase
endfunction

function automatic word_t rand_alu_imm(input int rd);
    int f3;
    int imm;
    f3  = rnd(8);
    imm = rnd(4096);
    if (f3 == 1) imm = rnd(32);
    if (f3 == 5) imm = rnd(32) + (rnd(2) * 32'h400);   // srli or srai
    return enc_i(imm, rnd(16), f3, rd, 7'h13);
endfunction

task automatic add_fillers(input int n);
    for (int i = 0; i < n; i++) prog.push_back(enc_i(rnd(4096), rnd(16), 0, 1 + rnd(15), 7'h13));
endtask

task automatic gen_random_program();
    int lf [5] = '{0, 1, 2, 4, 5};
    int bf [6] = '{0, 1, 4, 5, 6, 7};
    int cls;
    int rd;
    int f3;
    int k;
    prog.delete();
    prog.push_back(enc_u(32'h00030, 31, 7'h37));   // x31 points at the data region
    // each load width at each aligned offset, exposed by a word store
    foreach (lf[j]) begin
        for (int off = 0; off < 4; off += (lf[j] % 4 == 0) ? 1 : 2 * (lf[j] % 4)) begin
            prog.push_back(enc_i(64 + off, 31, lf[j], 1, 7'h03));
            prog.push_back(enc_s(rnd(64) * 4, 1, 31, 2));
        end
    end
    while (prog.size() < 200) begin
        cls = rnd(9);
        rd  = 1 + rnd(15);
        f3  = rnd(8);
        k   = rnd(3);
        case (cls)
            0: prog.push_back(rand_alu_imm(rd));
            1: prog.push_back(enc_r(((f3 == 0 || f3 == 5) && rnd(2) == 1) ? 32'h20 : 0,
                                    rnd(16), rnd(16), f3, rd));
            2: prog.push_back(enc_u(rnd(1 << 20), rd, (rnd(2) == 1) ? 32'h37 : 32'h17));
            3: begin
                f3 = rnd(3);
                prog.push_back(enc_s(mem_off(f3), rnd(16), 31, f3));
            end
            4: begin
                f3 = lf[rnd(5)];
                prog.push_back(enc_i(mem_off(f3), 31, f3, rd, 7'h03));
                prog.push_back(enc_s(rnd(64) * 4, rd, 31, 2));   // expose the loaded value
            end
            5: begin
                prog.push_back(enc_b(8 + 4 * k, rnd(16), rnd(16), bf[rnd(6)]));
                add_fillers(k + 1);
            end
            6: begin
                prog.push_back(enc_j(8 + 4 * k, rnd(16)));
                add_fillers(k + 1);
            end
            7: begin
                prog.push_back(enc_u(0, rd, 7'h17));   // auipc base for jalr
                prog.push_back(enc_i(12 + 4 * k, rd, 0, rnd(16), 7'h67));
                add_fillers(k + 1);
            end
            default: prog.push_back(32'h0ff0000f);   // fence
        endcase
        if (cls < 3 && rnd(3) == 0) prog.push_back(enc_s(rnd(64) * 4, rd, 31, 2));
    end
    prog.push_back(32'h0000006f);   // jal x0, 0
endtask

task automatic gen_fault_program();
    prog.delete();
    prog.push_back(enc_u(32'h00030, 31, 7'h37));
    prog.push_back(enc_i(123, 0, 0, 1, 7'h13));
    prog.push_back(enc_s(16, 1, 31, 2));
    prog.push_back(32'h00000073);           // ecall, not supported
    prog.push_back(enc_s(20, 1, 31, 2));    // never reached
endtask

function automatic word_t iss_alu(input logic [2:0] f3, input logic alt, input word_t a,
                                  input word_t b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'd0, $signed(a) < $signed(b)};
        3'd3:    return {31'd0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic iss_cond(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

task automatic iss_run(input word_t start);
    word_t      r [0:31];
    word_t      pc;
    word_t      npc;
    word_t      ins;
    word_t      imm;
    word_t      res;
    word_t      ea;
    word_t      sh;
    word_t      mask;
    logic [2:0] f3;
    logic [3:0] st;
    logic       wr;
    for (int i = 0; i < 32; i++) r[i] = '0;
    pc = start;
    exp_fault = fault_ok;
    for (int step = 0; step < 1000; step++) begin
        ins = iss_mem[pc[17:2]];
        exp_fetch.push_back(pc);
        f3  = ins[14:12];
        imm = {{20{ins[31]}}, ins[31:20]};
        res = '0;
        wr  = 1'b1;
        npc = pc + 4;
        case (ins[6:0])
            7'h37: res = {ins[31:12], 12'h000};
            7'h17: res = pc + {ins[31:12], 12'h000};
            7'h6f: begin
                res = pc + 4;
                npc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                res = pc + 4;
                npc = r[ins[19:15]] + imm;
            end
            7'h63: begin
                wr = 1'b0;
                if (iss_cond(f3, r[ins[19:15]], r[ins[24:20]]))
                    npc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'h13: res = iss_alu(f3, ins[30] && f3 == 3'd5, r[ins[19:15]], imm);
            7'h33: res = iss_alu(f3, ins[30], r[ins[19:15]], r[ins[24:20]]);
            7'h03: begin
                ea = r[ins[19:15]] + imm;
                sh = iss_mem[ea[17:2]] >> {ea[1:0], 3'b000};
                case (f3)
                    3'd0:    res = {{24{sh[7]}}, sh[7:0]};
                    3'd1:    res = {{16{sh[15]}}, sh[15:0]};
                    3'd4:    res = {24'd0, sh[7:0]};
                    3'd5:    res = {16'd0, sh[15:0]};
                    default: res = sh;
                endcase
            end
            7'h23: begin
                wr = 1'b0;
                ea = r[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                case (f3)
                    3'd0:    st = 4'b0001 << ea[1:0];
                    3'd1:    st = 4'b0011 << ea[1:0];
                    default: st = 4'b1111;
                endcase
                mask = {{8{st[3]}}, {8{st[2]}}, {8{st[1]}}, {8{st[0]}}};
                sh   = (r[ins[24:20]] << {ea[1:0], 3'b000}) & mask;
                iss_mem[ea[17:2]] = (iss_mem[ea[17:2]] & ~mask) | sh;
                exp_st_addr.push_back({14'd0, ea[17:2], 2'b00});
                exp_st_strb.push_back(st);
                exp_st_data.push_back(sh);
            end
            7'h0f: wr = 1'b0;
            default: begin
                exp_fault = fault_decode_err;   // system and unknown opcodes
                break;
            end
        endcase
        if (wr && ins[11:7] != 5'd0) r[ins[11:7]] = res;
        if (npc == pc) break;   // final self-jump
        pc = npc;
    end
endtask

// ==== verification/tb_rv32_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv32_core;
    import rv32_pkg::*;

    localparam word_t START = 32'h10000;

    logic       clk = 1'b0;
    logic       reset_n = 1'b0;
    logic       ram_wr_en;
    logic [3:0] ram_wr_strobe;
    logic [15:0] ram_addr;
    word_t      ram_data_in;
    word_t      ram_data_out;
    fault_e     core_fault;
    word_t      ram [0:65535];
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         limit = 100000;

    `include "tb_iss_model.svh"

    rv32_core #(
        .ADDR_WIDTH (16),
        .START_ADDR (START)
    ) dut0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .ram_wr_en_o     (ram_wr_en),
        .ram_wr_strobe_o (ram_wr_strobe),
        .ram_addr_o      (ram_addr),
        .ram_data_in_o   (ram_data_in),
        .ram_data_out_i  (ram_data_out),
        .core_fault_o    (core_fault)
    );

    assign ram_data_out = ram[ram_addr];   // combinational read

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (ram_wr_en === 1'b1) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_wr_strobe[i]) ram[ram_addr][8*i +: 8] <= ram_data_in[8*i +: 8];
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_fetch(input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: fetch address %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_store(input word_t got_a, input logic [3:0] got_s, input word_t got_d,
                               input word_t exp_a, input logic [3:0] exp_s, input word_t exp_d);
        word_t mask;
        mask = {{8{got_s[3]}}, {8{got_s[2]}}, {8{got_s[1]}}, {8{got_s[0]}}};
        checks++;
        if (got_a !== exp_a || got_s !== exp_s || (got_d & mask) !== exp_d) begin
            errors++;
            $display("FAIL %0t: store %h/%b/%h, expected %h/%b/%h", $time,
                     got_a, got_s, got_d & mask, exp_a, exp_s, exp_d);
        end
    endtask

    task automatic check_fault(input fault_e got, input fault_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: fault %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_wr_en(input logic exp);
        checks++;
        if (ram_wr_en !== exp) begin
            errors++;
            $display("FAIL %0t: ram_wr_en_o is %b, expected %b", $time, ram_wr_en, exp);
        end
    endtask

    task automatic run_program();
        int    fi = 0;
        int    si = 0;
        logic  stall = 1'b0;
        logic  is_store = 1'b0;
        word_t last;
        @(posedge clk);
        #1 reset_n = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            ram[a]     = fill_word(a);
            iss_mem[a] = ram[a];
        end
        foreach (prog[i]) begin
            ram[START[17:2] + i]     = prog[i];
            iss_mem[START[17:2] + i] = prog[i];
        end
        exp_fetch.delete();
        exp_st_addr.delete();
        exp_st_strb.delete();
        exp_st_data.delete();
        iss_run(START);
        repeat (10) @(posedge clk);
        #1 reset_n = 1'b1;
        check_wr_en(1'b0);   // state right after reset
        check_fault(core_fault, fault_ok);
        check_fetch({14'd0, ram_addr, 2'b00}, START & 32'h3ffff);
        while (fi < exp_fetch.size()) begin
            @(negedge clk);
            if (stall) begin
                stall = 1'b0;
                check_wr_en(is_store);
                if (is_store && si >= exp_st_addr.size()) begin
                    errors++;
                    $display("store at %0t that the model did not expect", $time);
                end else if (is_store) begin
                    check_store({14'd0, ram_addr, 2'b00}, ram_wr_strobe, ram_data_in,
                                exp_st_addr[si], exp_st_strb[si], exp_st_data[si]);
                    si++;
                end
            end else begin
                check_wr_en(1'b0);
                check_fetch({14'd0, ram_addr, 2'b00}, exp_fetch[fi] & 32'h3ffff);
                is_store = (ram_data_out[6:0] == 7'h23);
                stall    = is_store || (ram_data_out[6:0] == 7'h03);
                fi++;
            end
        end
        last = exp_fetch[exp_fetch.size() - 1] & 32'h3ffff;
        // core parks on the last fetch, self-jump or faulting instruction
        repeat (4) begin
            @(negedge clk);
            check_wr_en(1'b0);
            check_fetch({14'd0, ram_addr, 2'b00}, last);
            check_fault(core_fault, exp_fault);
        end
        if (si != exp_st_addr.size()) begin
            errors++;
            $display("only %0d of %0d expected stores were seen", si, exp_st_addr.size());
        end
    endtask

    initial begin
        int len2;
        gen_fault_program();
        len2 = prog.size();
        gen_random_program();
        limit = 3 * (prog.size() + len2) + 100;
        run_program();
        gen_fault_program();
        run_program();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
